// File: Makefile
SIM      = verilator
SIMFLAGS = --binary --timing --assert -j 0
TOP      = tb_core
FILELIST = compile.f
OBJDIR   = obj_dir
LOG      = sim.log

SOURCES = $(shell grep -v '^+' $(FILELIST)) $(wildcard sim/*.svh)
BIN     = $(OBJDIR)/V$(TOP)

.PHONY: all run check clean

all: check

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(SIMFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

$(LOG): $(BIN)
	./$(BIN) > $(LOG)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -q '^\*\* PASS \*\*$$' $(LOG)

check: $(LOG)
	@grep -q '^\*\* PASS \*\*$$' $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

// File: compile.f
+incdir+sim
verilog/rv_isa_pkg.sv
verilog/core_pkg.sv
verilog/core_if.sv
verilog/fetch_unit.sv
verilog/inst_decode.sv
verilog/reg_file.sv
verilog/alu_execute.sv
verilog/result_commit.sv
verilog/rv_core_top.sv
sim/tb_core.sv

// File: sim/rv_ref_model.svh
`ifndef RV_REF_MODEL_SVH
`define RV_REF_MODEL_SVH

// program image and architectural state of the model
logic [31:0] prog [256];
logic [31:0] mregs [32];
logic [31:0] mpc;

// one random word, about 85% supported
function automatic logic [31:0] gen_inst();
	logic [31:0] w;
	int          pick;
	w    = $random(seed);
	pick = $unsigned($random(seed)) % 100;
	if (pick < 8) begin
		w[6:0] = OPC_LUI;
	end else if (pick < 16) begin
		w[6:0] = OPC_AUIPC;
	end else if (pick < 22) begin
		w[6:0] = OPC_JAL;
	end else if (pick < 28) begin
		w[6:0]   = OPC_JALR;
		w[14:12] = F3_JALR;
	end else if (pick < 44) begin
		w[6:0] = OPC_BRANCH;
		// 010 and 011 are not branches
		if (w[14:13] == 2'b01)
			w[13] = 1'b0;
	end else if (pick < 66) begin
		w[6:0] = OPC_OP_IMM;
		if (w[14:12] == F3_SLL)
			w[31:25] = F7_BASE;
		else if (w[14:12] == F3_SR)
			w[31:25] = {1'b0, w[30], 5'b0};
	end else if (pick < 85) begin
		w[6:0] = OPC_OP;
		if (w[14:12] == F3_ADD || w[14:12] == F3_SR)
			w[31:25] = {1'b0, w[30], 5'b0};
		else
			w[31:25] = F7_BASE;
	end else begin
		case (pick % 5)
			0: w[6:0] = OPC_LOAD;
			1: w[6:0] = OPC_STORE;
			2: w[6:0] = OPC_SYSTEM;
			3: begin
				// multiply group, not in RV32I
				w[6:0]   = OPC_OP;
				w[31:25] = 7'b0000001;
			end
			default: w[6:0] = 7'b0001111;
		endcase
	end
	return w;
endfunction

task automatic init_model();
	logic [31:0] w;
	for (int i = 0; i < 256; i++)
		prog[i] = gen_inst();
	// prelude: addi x1..x31 so nothing is read before it is written
	for (int i = 1; i < 32; i++) begin
		w           = $random(seed);
		prog[i - 1] = {w[31:20], 5'd0, F3_ADD, 5'(i), OPC_OP_IMM};
	end
	for (int i = 0; i < 32; i++)
		mregs[i] = '0;
	mpc = RESET_PC;
endtask

function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
	input logic [31:0] a, input logic [31:0] b);
	case (f3)
		F3_ADD:  return alt ? a - b : a + b;
		F3_SLL:  return a << b[4:0];
		F3_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
		F3_SLTU: return (a < b) ? 32'd1 : 32'd0;
		F3_XOR:  return a ^ b;
		F3_SR: begin
			if (alt)
				return $signed(a) >>> b[4:0];
			else
				return a >> b[4:0];
		end
		F3_OR:   return a | b;
		default: return a & b;
	endcase
endfunction

// executes the word at mpc, updates registers and pc
task automatic model_step(output bit ill, output bit we, output logic [4:0] rd,
	output logic [31:0] val, output bit ctrl, output bit has_val);
	logic [31:0] ins;
	logic [31:0] a;
	logic [31:0] b;
	logic [31:0] npc;
	logic [31:0] immi;
	logic [31:0] immb;
	logic [31:0] immj;
	logic [31:0] immu;
	logic [2:0]  f3;
	logic [6:0]  f7;
	bit          take;
	ins     = prog[mpc[9:2]];
	f3      = ins[14:12];
	f7      = ins[31:25];
	rd      = ins[11:7];
	a       = mregs[ins[19:15]];
	b       = mregs[ins[24:20]];
	immi    = {{20{ins[31]}}, ins[31:20]};
	immb    = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
	immj    = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
	immu    = {ins[31:12], 12'b0};
	npc     = mpc + 32'd4;
	ill     = 1'b0;
	we      = 1'b1;
	val     = '0;
	ctrl    = 1'b0;
	has_val = 1'b1;
	take    = 1'b0;
	case (ins[6:0])
		OPC_LUI:   val = immu;
		OPC_AUIPC: val = mpc + immu;
		OPC_JAL: begin
			ctrl = 1'b1;
			val  = mpc + 32'd4;
			npc  = mpc + immj;
		end
		OPC_JALR: begin
			ill  = (f3 != F3_JALR);
			ctrl = 1'b1;
			val  = mpc + 32'd4;
			npc  = a + immi;
		end
		OPC_BRANCH: begin
			ctrl    = 1'b1;
			we      = 1'b0;
			has_val = 1'b0;
			case (f3)
				F3_BEQ:  take = (a == b);
				F3_BNE:  take = (a != b);
				F3_BLT:  take = ($signed(a) < $signed(b));
				F3_BGE:  take = ($signed(a) >= $signed(b));
				F3_BLTU: take = (a < b);
				F3_BGEU: take = (a >= b);
				default: ill = 1'b1;
			endcase
			if (take)
				npc = mpc + immb;
		end
		OPC_OP_IMM: begin
			ill = (f3 == F3_SLL && f7 != F7_BASE) ||
				(f3 == F3_SR && f7 != F7_BASE && f7 != F7_ALT);
			val = alu_ref(f3, f3 == F3_SR && ins[30], a, immi);
		end
		OPC_OP: begin
			ill = !(f7 == F7_BASE || (f7 == F7_ALT && (f3 == F3_ADD || f3 == F3_SR)));
			val = alu_ref(f3, ins[30], a, b);
		end
		default: ill = 1'b1;
	endcase
	if (ill) begin
		we      = 1'b0;
		ctrl    = 1'b0;
		has_val = 1'b0;
		npc     = mpc + 32'd4;
	end
	if (rd == 5'd0)
		we = 1'b0;
	if (we)
		mregs[rd] = val;
	mpc = {npc[31:2], 2'b00};
endtask

`endif

// File: sim/tb_core.sv
`timescale 1ns/100ps
`default_nettype none

module tb_core
	import rv_isa_pkg::*, core_pkg::*;
();

	localparam int N_RETIRE = 2000;
	localparam int TIMEOUT  = 200;
	localparam int T_FETCH  = 0;
	localparam int T_ALU    = 1;
	localparam int T_CTRL   = 2;
	localparam int T_ILL    = 3;
	localparam int T_TIME   = 4;

	logic        clk;
	logic        rst;
	logic        ar_ready_i;
	logic [31:0] r_data_i;
	logic [1:0]  r_resp_i;
	logic        r_valid_i;
	logic [31:0] ar_addr_o;
	logic        ar_valid_o;
	logic        r_ready_o;
	logic        fetch_err_o;
	logic        retire_o;
	logic [31:0] retire_pc_o;
	logic        rd_we_o;
	logic [4:0]  rd_addr_o;
	logic [31:0] rd_data_o;
	logic        illegal_o;

	int seed;
	int chk [5];
	int errs [5];
	int retired;
	int fetch_errs;
	int total_chk;
	int total_err;
	bit hung;
	bit first_fetch;
	bit last_ctrl;
	bit last_ill;

	`include "rv_ref_model.svh"

	rv_core_top UUT (
		.clk(clk), .rst(rst),
		.ar_ready_i(ar_ready_i), .r_data_i(r_data_i), .r_resp_i(r_resp_i),
		.r_valid_i(r_valid_i), .ar_addr_o(ar_addr_o), .ar_valid_o(ar_valid_o),
		.r_ready_o(r_ready_o), .fetch_err_o(fetch_err_o), .retire_o(retire_o),
		.retire_pc_o(retire_pc_o), .rd_we_o(rd_we_o), .rd_addr_o(rd_addr_o),
		.rd_data_o(rd_data_o), .illegal_o(illegal_o)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	function automatic string test_name(input int t);
		case (t)
			T_FETCH: return "fetch order";
			T_ALU:   return "alu results";
			T_CTRL:  return "control flow";
			T_ILL:   return "illegal inst";
			default: return "timing/reset";
		endcase
	endfunction

	task automatic check(input int t, input bit ok, input string msg);
		chk[t]++;
		assert (ok) else begin
			$display("Fail at %0d ns: %s", $time, msg);
			errs[t]++;
		end
	endtask

	function automatic bit sig_level(input int which);
		case (which)
			0:       return ar_valid_o;
			1:       return r_ready_o;
			default: return retire_o;
		endcase
	endfunction

	// counts falling edges until the signal is high
	task automatic wait_high(input int which, input string what, output int cycles);
		cycles = 0;
		while (!sig_level(which) && cycles < TIMEOUT) begin
			@(negedge clk);
			cycles++;
		end
		if (!sig_level(which)) begin
			$display("Timeout: %s did not rise within %0d cycles", what, TIMEOUT);
			hung = 1'b1;
		end
	endtask

	// memory side of one fetch and the retirement it leads to
	task automatic fetch_and_retire();
		int          n;
		int          tsel;
		logic [31:0] addr;
		logic [31:0] rpc;
		logic [31:0] val;
		logic [4:0]  rd;
		bit          bad;
		bit          ill;
		bit          we;
		bit          ctrl;
		bit          has_val;
		wait_high(0, "ar_valid_o", n);
		if (hung)
			return;
		repeat ($unsigned($random(seed)) % 6) @(negedge clk);
		addr       = ar_addr_o;
		ar_ready_i = 1'b1;
		check(T_FETCH, addr == mpc, $sformatf("fetch address %h, expected %h", addr, mpc));
		if (first_fetch)
			check(T_TIME, addr == RESET_PC, $sformatf("first fetch at %h", addr));
		if (last_ctrl)
			check(T_CTRL, addr == mpc, $sformatf("target %h, expected %h", addr, mpc));
		if (last_ill)
			check(T_ILL, addr == mpc, $sformatf("pc after illegal %h, expected %h", addr, mpc));
		first_fetch = 1'b0;
		@(negedge clk);
		ar_ready_i = 1'b0;

		wait_high(1, "r_ready_o", n);
		if (hung)
			return;
		repeat ($unsigned($random(seed)) % 6) @(negedge clk);
		bad       = (($random(seed) & 15) == 0);
		r_valid_i = 1'b1;
		r_data_i  = prog[addr[9:2]];
		r_resp_i  = bad ? 2'b10 : RESP_OKAY;
		@(negedge clk);
		r_valid_i = 1'b0;
		r_resp_i  = RESP_OKAY;
		check(T_FETCH, fetch_err_o == bad,
			$sformatf("fetch_err_o %b after beat with error %b", fetch_err_o, bad));
		if (bad) begin
			// same pc is expected on the next address
			fetch_errs++;
			return;
		end

		// this edge is the ISSUE cycle
		wait_high(2, "retire_o", n);
		if (hung)
			return;
		check(T_TIME, n == 3, $sformatf("retire_o %0d cycles after ISSUE", n));
		rpc = mpc;
		model_step(ill, we, rd, val, ctrl, has_val);
		tsel = ill ? T_ILL : (ctrl ? T_CTRL : T_ALU);
		check(tsel, retire_pc_o == rpc,
			$sformatf("retire_pc_o %h, expected %h", retire_pc_o, rpc));
		check(tsel, rd_we_o == we,
			$sformatf("rd_we_o %b, expected %b at pc %h", rd_we_o, we, rpc));
		check(tsel, illegal_o == ill,
			$sformatf("illegal_o %b, expected %b at pc %h", illegal_o, ill, rpc));
		if (has_val) begin
			check(tsel, rd_addr_o == rd,
				$sformatf("rd_addr_o %0d, expected %0d at pc %h", rd_addr_o, rd, rpc));
			check(tsel, rd_data_o == val,
				$sformatf("rd_data_o %h, expected %h at pc %h", rd_data_o, val, rpc));
		end
		retired++;
		last_ctrl = ctrl;
		last_ill  = ill;
		@(negedge clk);
		check(T_TIME, !retire_o, "retire_o high in two consecutive cycles");
	endtask

	initial begin
		seed        = 32'h1523e9d5;
		rst         = 1'b1;
		ar_ready_i  = 1'b0;
		r_valid_i   = 1'b0;
		r_data_i    = '0;
		r_resp_i    = RESP_OKAY;
		hung        = 1'b0;
		first_fetch = 1'b1;
		last_ctrl   = 1'b0;
		last_ill    = 1'b0;
		retired     = 0;
		fetch_errs  = 0;
		total_chk   = 0;
		total_err   = 0;
		for (int t = 0; t < 5; t++) begin
			chk[t]  = 0;
			errs[t] = 0;
		end
		init_model();

		repeat (8) @(negedge clk);
		check(T_TIME, !ar_valid_o && !r_ready_o && !fetch_err_o,
			"read channel active in reset");
		check(T_TIME, !retire_o && !rd_we_o && !illegal_o, "retirement report in reset");
		rst = 1'b0;

		while (retired < N_RETIRE && !hung)
			fetch_and_retire();

		for (int t = 0; t < 5; t++) begin
			$display("test %-13s %0d checks, %0d errors", test_name(t), chk[t], errs[t]);
			total_chk += chk[t];
			total_err += errs[t];
		end
		$display("%0d retired, %0d fetch errors, %0d checks, %0d errors",
			retired, fetch_errs, total_chk, total_err);
		if (total_err == 0 && !hung)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

`default_nettype wire

// File: verilog/alu_execute.sv
`timescale 1ns/100ps
`default_nettype none

module alu_execute
	import rv_isa_pkg::*, core_pkg::*;
(
	input wire         clk,
	input wire         rst,
	dec_exe_if.sink    dec_i,
	exe_res_if.source  res_o
);

	logic [XLEN-1:0] alu_out;
	logic [XLEN-1:0] pc_plus4;
	logic [XLEN-1:0] target;
	logic [4:0]      shamt;
	logic            taken;
	logic            jump;

	assign shamt = dec_i.op_b[4:0];

	always_comb begin
		case (dec_i.alu_op)
			ALU_ADD:    alu_out = dec_i.op_a + dec_i.op_b;
			ALU_SUB:    alu_out = dec_i.op_a - dec_i.op_b;
			ALU_SLL:    alu_out = dec_i.op_a << shamt;
			ALU_SLT:    alu_out = {{(XLEN-1){1'b0}}, $signed(dec_i.op_a) < $signed(dec_i.op_b)};
			ALU_SLTU:   alu_out = {{(XLEN-1){1'b0}}, dec_i.op_a < dec_i.op_b};
			ALU_XOR:    alu_out = dec_i.op_a ^ dec_i.op_b;
			ALU_SRL:    alu_out = dec_i.op_a >> shamt;
			ALU_SRA:    alu_out = $signed(dec_i.op_a) >>> shamt;
			ALU_OR:     alu_out = dec_i.op_a | dec_i.op_b;
			ALU_AND:    alu_out = dec_i.op_a & dec_i.op_b;
			ALU_PASS_B: alu_out = dec_i.op_b;
			default:    alu_out = '0;
		endcase
	end

	// branch compare, rs1 sits in op_a
	always_comb begin
		case (dec_i.funct3)
			F3_BEQ:  taken = (dec_i.op_a == dec_i.rs2_val);
			F3_BNE:  taken = (dec_i.op_a != dec_i.rs2_val);
			F3_BLT:  taken = ($signed(dec_i.op_a) < $signed(dec_i.rs2_val));
			F3_BGE:  taken = ($signed(dec_i.op_a) >= $signed(dec_i.rs2_val));
			F3_BLTU: taken = (dec_i.op_a < dec_i.rs2_val);
			F3_BGEU: taken = (dec_i.op_a >= dec_i.rs2_val);
			default: taken = 1'b0;
		endcase
	end

	assign jump     = (dec_i.branch == BR_JAL) || (dec_i.branch == BR_JALR);
	assign pc_plus4 = dec_i.pc + XLEN'(4);
	assign target   = ((dec_i.branch == BR_JALR) ? dec_i.op_a : dec_i.pc) + dec_i.imm;

	always_ff @(posedge clk) begin
		if (rst)
			res_o.valid <= 1'b0;
		else
			res_o.valid <= dec_i.valid;
	end

	always_ff @(posedge clk) begin
		if (dec_i.valid) begin
			res_o.pc      <= dec_i.pc;
			res_o.rd      <= dec_i.rd;
			res_o.rd_we   <= dec_i.rd_we;
			res_o.illegal <= dec_i.illegal;
			res_o.result  <= jump ? pc_plus4 : alu_out;
			// targets are word aligned
			if (jump || (dec_i.branch == BR_COND && taken))
				res_o.next_pc <= {target[XLEN-1:2], 2'b00};
			else
				res_o.next_pc <= {pc_plus4[XLEN-1:2], 2'b00};
		end
	end

endmodule

`default_nettype wire

// File: verilog/core_if.sv
`timescale 1ns/100ps
`default_nettype none

// decode to execute bundle
interface dec_exe_if import rv_isa_pkg::*, core_pkg::*; ();
	logic              valid;
	logic [XLEN-1:0]   pc;
	alu_op_e           alu_op;
	logic [XLEN-1:0]   op_a;
	logic [XLEN-1:0]   op_b;
	logic [XLEN-1:0]   rs2_val;
	logic [XLEN-1:0]   imm;
	logic [2:0]        funct3;
	branch_e           branch;
	logic [REG_AW-1:0] rd;
	logic              rd_we;
	logic              illegal;

	modport source (output valid, pc, alu_op, op_a, op_b, rs2_val, imm, funct3, branch,
		rd, rd_we, illegal);
	modport sink (input valid, pc, alu_op, op_a, op_b, rs2_val, imm, funct3, branch,
		rd, rd_we, illegal);
endinterface

// execute to result bundle
interface exe_res_if import core_pkg::*; ();
	logic              valid;
	logic [XLEN-1:0]   pc;
	logic [XLEN-1:0]   result;
	logic [REG_AW-1:0] rd;
	logic              rd_we;
	logic [XLEN-1:0]   next_pc;
	logic              illegal;

	modport source (output valid, pc, result, rd, rd_we, next_pc, illegal);
	modport sink (input valid, pc, result, rd, rd_we, next_pc, illegal);
endinterface

`default_nettype wire

// File: verilog/core_pkg.sv
`default_nettype none

package core_pkg;

	localparam int XLEN   = 32;
	localparam int REG_AW = 5;

	localparam logic [XLEN-1:0] RESET_PC = 32'h0;

	// read response code for a good beat
	localparam logic [1:0] RESP_OKAY = 2'b00;

	typedef enum logic [1:0] {
		ST_ADDR,
		ST_DATA,
		ST_ISSUE,
		ST_WAIT_DONE
	} fetch_state_e;

	typedef enum logic [2:0] {
		BR_NONE,
		BR_COND,
		BR_JAL,
		BR_JALR
	} branch_e;

endpackage

`default_nettype wire

// File: verilog/fetch_unit.sv
`timescale 1ns/100ps
`default_nettype none

module fetch_unit
	import core_pkg::*;
(
	input  wire             clk,
	input  wire             rst,
	input  wire             ar_ready_i,
	input  wire  [XLEN-1:0] r_data_i,
	input  wire  [1:0]      r_resp_i,
	input  wire             r_valid_i,
	input  wire             done_i,
	input  wire  [XLEN-1:0] next_pc_i,
	output logic [XLEN-1:0] ar_addr_o,
	output logic            ar_valid_o,
	output logic            r_ready_o,
	output logic            fetch_err_o,
	output logic            inst_valid_o,
	output logic [XLEN-1:0] inst_o,
	output logic [XLEN-1:0] pc_o
);

	fetch_state_e    state;
	fetch_state_e    state_nxt;
	logic [XLEN-1:0] pc;
	logic            ar_fire;
	logic            r_fire;
	logic            r_ok;

	assign ar_fire = ar_valid_o & ar_ready_i;
	assign r_fire  = r_ready_o & r_valid_i;
	assign r_ok    = (r_resp_i == RESP_OKAY);

	always_comb begin
		state_nxt = state;
		case (state)
			ST_ADDR: begin
				if (ar_fire)
					state_nxt = ST_DATA;
			end
			ST_DATA: begin
				// a bad response goes back and asks for the same pc again
				if (r_fire)
					state_nxt = r_ok ? ST_ISSUE : ST_ADDR;
			end
			ST_ISSUE:
				state_nxt = ST_WAIT_DONE;
			ST_WAIT_DONE: begin
				if (done_i)
					state_nxt = ST_ADDR;
			end
			default:
				state_nxt = ST_ADDR;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state       <= ST_ADDR;
			pc          <= RESET_PC;
			ar_valid_o  <= 1'b0;
			fetch_err_o <= 1'b0;
		end else begin
			state       <= state_nxt;
			ar_valid_o  <= (state_nxt == ST_ADDR);
			fetch_err_o <= r_fire & ~r_ok;
			if (done_i && state == ST_WAIT_DONE)
				pc <= next_pc_i;
		end
	end

	// instruction word held until decode has it
	always_ff @(posedge clk) begin
		if (r_fire && r_ok)
			inst_o <= r_data_i;
	end

	assign ar_addr_o    = pc;
	assign r_ready_o    = (state == ST_DATA);
	assign inst_valid_o = (state == ST_ISSUE);
	assign pc_o         = pc;

	a_addr_held: assert property (@(posedge clk) disable iff (rst)
		ar_valid_o && !ar_ready_i |=> ar_valid_o && $stable(ar_addr_o));

	// result block only reports back for the one instruction in flight
	a_done_in_wait: assert property (@(posedge clk) disable iff (rst)
		done_i |-> state == ST_WAIT_DONE);

endmodule

`default_nettype wire

// File: verilog/inst_decode.sv
`timescale 1ns/100ps
`default_nettype none

module inst_decode
	import rv_isa_pkg::*, core_pkg::*;
(
	input  wire               clk,
	input  wire               rst,
	input  wire               inst_valid_i,
	input  wire  [XLEN-1:0]   inst_i,
	input  wire  [XLEN-1:0]   pc_i,
	input  wire  [XLEN-1:0]   rs1_data_i,
	input  wire  [XLEN-1:0]   rs2_data_i,
	output logic [REG_AW-1:0] rs1_addr_o,
	output logic [REG_AW-1:0] rs2_addr_o,
	dec_exe_if.source         dec_o
);

	opcode_e           opcode;
	logic [2:0]        funct3;
	logic [6:0]        funct7;
	logic [REG_AW-1:0] rd;
	logic [XLEN-1:0]   imm;
	logic              legal;
	logic              writes_rd;
	logic              use_pc;
	logic              use_imm;
	alu_op_e           alu_op;
	branch_e           branch;

	function automatic alu_op_e alu_sel(input logic [2:0] f3, input logic alt);
		alu_op_e op;
		case (f3)
			F3_ADD:  op = alt ? ALU_SUB : ALU_ADD;
			F3_SLL:  op = ALU_SLL;
			F3_SLT:  op = ALU_SLT;
			F3_SLTU: op = ALU_SLTU;
			F3_XOR:  op = ALU_XOR;
			F3_SR:   op = alt ? ALU_SRA : ALU_SRL;
			F3_OR:   op = ALU_OR;
			default: op = ALU_AND;
		endcase
		return op;
	endfunction

	assign opcode     = opcode_e'(inst_i[6:0]);
	assign funct3     = inst_i[14:12];
	assign funct7     = inst_i[31:25];
	assign rd         = inst_i[11:7];
	assign rs1_addr_o = inst_i[19:15];
	assign rs2_addr_o = inst_i[24:20];

	// immediate by format, I-type otherwise
	always_comb begin
		case (opcode)
			OPC_STORE:  imm = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
			OPC_BRANCH: imm = {{19{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25],
				inst_i[11:8], 1'b0};
			OPC_LUI, OPC_AUIPC:
				imm = {inst_i[31:12], 12'b0};
			OPC_JAL:    imm = {{11{inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20],
				inst_i[30:21], 1'b0};
			default:    imm = {{20{inst_i[31]}}, inst_i[31:20]};
		endcase
	end

	always_comb begin
		legal     = 1'b0;
		writes_rd = 1'b1;
		use_pc    = 1'b0;
		use_imm   = 1'b1;
		alu_op    = ALU_ADD;
		branch    = BR_NONE;
		case (opcode)
			OPC_LUI: begin
				legal  = 1'b1;
				alu_op = ALU_PASS_B;
			end
			OPC_AUIPC: begin
				legal  = 1'b1;
				use_pc = 1'b1;
			end
			OPC_JAL: begin
				legal  = 1'b1;
				branch = BR_JAL;
			end
			OPC_JALR: begin
				legal  = (funct3 == F3_JALR);
				branch = BR_JALR;
			end
			OPC_BRANCH: begin
				// funct3 010 and 011 are unused
				legal     = (funct3[2:1] != 2'b01);
				writes_rd = 1'b0;
				use_imm   = 1'b0;
				branch    = BR_COND;
			end
			OPC_OP_IMM: begin
				alu_op = alu_sel(funct3, (funct3 == F3_SR) & funct7[5]);
				if (funct3 == F3_SLL)
					legal = (funct7 == F7_BASE);
				else if (funct3 == F3_SR)
					legal = (funct7 == F7_BASE) || (funct7 == F7_ALT);
				else
					legal = 1'b1;
			end
			OPC_OP: begin
				use_imm = 1'b0;
				alu_op  = alu_sel(funct3, funct7[5]);
				legal   = (funct7 == F7_BASE) ||
					(funct7 == F7_ALT && (funct3 == F3_ADD || funct3 == F3_SR));
			end
			default:
				legal = 1'b0;
		endcase
		// illegal words retire as a plain pc+4 step
		if (!legal)
			branch = BR_NONE;
	end

	always_ff @(posedge clk) begin
		if (rst)
			dec_o.valid <= 1'b0;
		else
			dec_o.valid <= inst_valid_i;
	end

	always_ff @(posedge clk) begin
		if (inst_valid_i) begin
			dec_o.pc      <= pc_i;
			dec_o.alu_op  <= alu_op;
			dec_o.op_a    <= use_pc ? pc_i : rs1_data_i;
			dec_o.op_b    <= use_imm ? imm : rs2_data_i;
			dec_o.rs2_val <= rs2_data_i;
			dec_o.imm     <= imm;
			dec_o.funct3  <= funct3;
			dec_o.branch  <= branch;
			dec_o.rd      <= rd;
			dec_o.rd_we   <= legal & writes_rd & (rd != '0);
			dec_o.illegal <= ~legal;
		end
	end

endmodule

`default_nettype wire

// File: verilog/reg_file.sv
`timescale 1ns/100ps
`default_nettype none

module reg_file
	import core_pkg::*;
(
	input  wire               clk,
	input  wire               rst,
	input  wire  [REG_AW-1:0] ra1_i,
	input  wire  [REG_AW-1:0] ra2_i,
	input  wire               we_i,
	input  wire  [REG_AW-1:0] wa_i,
	input  wire  [XLEN-1:0]   wd_i,
	output logic [XLEN-1:0]   rd1_o,
	output logic [XLEN-1:0]   rd2_o
);

	// x1..x31, x0 reads as zero
	logic [XLEN-1:0] regs [31:1];

	assign rd1_o = (ra1_i == '0) ? '0 : regs[ra1_i];
	assign rd2_o = (ra2_i == '0) ? '0 : regs[ra2_i];

	always_ff @(posedge clk) begin
		if (we_i && wa_i != '0)
			regs[wa_i] <= wd_i;
	end

	// decode already drops rd_we for rd = x0
	a_no_x0_write: assert property (@(posedge clk) disable iff (rst)
		we_i |-> wa_i != '0);

endmodule

`default_nettype wire

// File: verilog/result_commit.sv
`timescale 1ns/100ps
`default_nettype none

module result_commit
	import core_pkg::*;
(
	input  wire               clk,
	input  wire               rst,
	exe_res_if.sink           res_i,
	output logic              we_o,
	output logic [REG_AW-1:0] wa_o,
	output logic [XLEN-1:0]   wd_o,
	output logic              done_o,
	output logic [XLEN-1:0]   next_pc_o,
	output logic              retire_o,
	output logic [XLEN-1:0]   retire_pc_o,
	output logic              rd_we_o,
	output logic [REG_AW-1:0] rd_addr_o,
	output logic [XLEN-1:0]   rd_data_o,
	output logic              illegal_o
);

	logic rd_we_q;
	logic illegal_q;

	always_ff @(posedge clk) begin
		if (rst)
			retire_o <= 1'b0;
		else
			retire_o <= res_i.valid;
	end

	// retirement record
	always_ff @(posedge clk) begin
		if (res_i.valid) begin
			retire_pc_o <= res_i.pc;
			rd_addr_o   <= res_i.rd;
			rd_data_o   <= res_i.result;
			next_pc_o   <= res_i.next_pc;
			rd_we_q     <= res_i.rd_we;
			illegal_q   <= res_i.illegal;
		end
	end

	assign rd_we_o   = retire_o & rd_we_q;
	assign illegal_o = retire_o & illegal_q;

	// write-back and fetch restart share the retire cycle
	assign we_o   = rd_we_o;
	assign wa_o   = rd_addr_o;
	assign wd_o   = rd_data_o;
	assign done_o = retire_o;

	// one instruction in flight, so retirements never touch
	a_retire_gap: assert property (@(posedge clk) disable iff (rst)
		retire_o |=> !retire_o);

endmodule

`default_nettype wire

// File: verilog/rv_core_top.sv
`timescale 1ns/100ps
`default_nettype none

module rv_core_top
	import core_pkg::*;
(
	input  wire               clk,
	input  wire               rst,
	input  wire               ar_ready_i,
	input  wire  [XLEN-1:0]   r_data_i,
	input  wire  [1:0]        r_resp_i,
	input  wire               r_valid_i,
	output logic [XLEN-1:0]   ar_addr_o,
	output logic              ar_valid_o,
	output logic              r_ready_o,
	output logic              fetch_err_o,
	output logic              retire_o,
	output logic [XLEN-1:0]   retire_pc_o,
	output logic              rd_we_o,
	output logic [REG_AW-1:0] rd_addr_o,
	output logic [XLEN-1:0]   rd_data_o,
	output logic              illegal_o
);

	logic              inst_valid;
	logic [XLEN-1:0]   inst;
	logic [XLEN-1:0]   pc;
	logic [REG_AW-1:0] rs1_addr;
	logic [REG_AW-1:0] rs2_addr;
	logic [XLEN-1:0]   rs1_data;
	logic [XLEN-1:0]   rs2_data;
	logic              rf_we;
	logic [REG_AW-1:0] rf_wa;
	logic [XLEN-1:0]   rf_wd;
	logic              done;
	logic [XLEN-1:0]   next_pc;

	dec_exe_if dec_exe ();
	exe_res_if exe_res ();

	fetch_unit u_fetch (
		.clk(clk), .rst(rst),
		.ar_ready_i(ar_ready_i), .r_data_i(r_data_i), .r_resp_i(r_resp_i),
		.r_valid_i(r_valid_i), .done_i(done), .next_pc_i(next_pc),
		.ar_addr_o(ar_addr_o), .ar_valid_o(ar_valid_o), .r_ready_o(r_ready_o),
		.fetch_err_o(fetch_err_o), .inst_valid_o(inst_valid), .inst_o(inst), .pc_o(pc)
	);

	inst_decode u_decode (
		.clk(clk), .rst(rst),
		.inst_valid_i(inst_valid), .inst_i(inst), .pc_i(pc),
		.rs1_data_i(rs1_data), .rs2_data_i(rs2_data),
		.rs1_addr_o(rs1_addr), .rs2_addr_o(rs2_addr), .dec_o(dec_exe.source)
	);

	reg_file u_regs (
		.clk(clk), .rst(rst),
		.ra1_i(rs1_addr), .ra2_i(rs2_addr),
		.we_i(rf_we), .wa_i(rf_wa), .wd_i(rf_wd),
		.rd1_o(rs1_data), .rd2_o(rs2_data)
	);

	alu_execute u_execute (
		.clk(clk), .rst(rst), .dec_i(dec_exe.sink), .res_o(exe_res.source)
	);

	result_commit u_commit (
		.clk(clk), .rst(rst), .res_i(exe_res.sink),
		.we_o(rf_we), .wa_o(rf_wa), .wd_o(rf_wd), .done_o(done), .next_pc_o(next_pc),
		.retire_o(retire_o), .retire_pc_o(retire_pc_o), .rd_we_o(rd_we_o),
		.rd_addr_o(rd_addr_o), .rd_data_o(rd_data_o), .illegal_o(illegal_o)
	);

endmodule

`default_nettype wire

// File: verilog/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

	// major opcodes, bits [6:0]
	typedef enum logic [6:0] {
		OPC_LUI    = 7'b0110111,
		OPC_AUIPC  = 7'b0010111,
		OPC_JAL    = 7'b1101111,
		OPC_JALR   = 7'b1100111,
		OPC_BRANCH = 7'b1100011,
		OPC_LOAD   = 7'b0000011,
		OPC_STORE  = 7'b0100011,
		OPC_OP_IMM = 7'b0010011,
		OPC_OP     = 7'b0110011,
		OPC_SYSTEM = 7'b1110011
	} opcode_e;

	// alu group funct3
	localparam logic [2:0] F3_ADD  = 3'b000;
	localparam logic [2:0] F3_SLL  = 3'b001;
	localparam logic [2:0] F3_SLT  = 3'b010;
	localparam logic [2:0] F3_SLTU = 3'b011;
	localparam logic [2:0] F3_XOR  = 3'b100;
	localparam logic [2:0] F3_SR   = 3'b101;
	localparam logic [2:0] F3_OR   = 3'b110;
	localparam logic [2:0] F3_AND  = 3'b111;

	// branch funct3
	localparam logic [2:0] F3_BEQ  = 3'b000;
	localparam logic [2:0] F3_BNE  = 3'b001;
	localparam logic [2:0] F3_BLT  = 3'b100;
	localparam logic [2:0] F3_BGE  = 3'b101;
	localparam logic [2:0] F3_BLTU = 3'b110;
	localparam logic [2:0] F3_BGEU = 3'b111;

	localparam logic [2:0] F3_JALR = 3'b000;

	// funct7 of the base set and of SUB / SRA
	localparam logic [6:0] F7_BASE = 7'b0000000;
	localparam logic [6:0] F7_ALT  = 7'b0100000;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_SLL,
		ALU_SLT,
		ALU_SLTU,
		ALU_XOR,
		ALU_SRL,
		ALU_SRA,
		ALU_OR,
		ALU_AND,
		ALU_PASS_B
	} alu_op_e;

endpackage

`default_nettype wire
